// File: logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN               = 32;
    localparam int UART_DATA_SIZE     = 8;
    localparam int UART_BAUD_DIV_SIZE = 4;
    localparam int UART_CTRL_SIZE     = 20;

    // Channel number sits above the register index in the address
    localparam int CH_ADDR_LSB = 6;

    // Register index, taken from address bits 5:2
    typedef enum logic [3:0] {
        TXDATA   = 4'd0,
        RXDATA   = 4'd1,
        BAUD     = 4'd2,
        STATUS   = 4'd3,
        TXCTRL   = 4'd4,
        RXCTRL   = 4'd5,
        INT_MASK = 4'd6
    } type_uart_regs_e;

    // Status register bits
    localparam int ST_TX_READY  = 0;
    localparam int ST_RX_FULL   = 1;
    localparam int ST_FRAME_ERR = 4;

    // One serial bit lasts (divisor + 1) * BIT_TICKS_PER_DIV clocks
    localparam logic [UART_BAUD_DIV_SIZE-1:0] BAUD_RESET = 4'd8;
    localparam int BIT_TICKS_PER_DIV = 4;

    // --------------------------------------------------
    // Bus word views
    // --------------------------------------------------
    typedef struct packed {
        logic                             flag;
        logic [XLEN-UART_DATA_SIZE-2:0]   pad;
        logic [UART_DATA_SIZE-1:0]        data;
    } uart_data_view_s;

    typedef struct packed {
        logic [XLEN-UART_CTRL_SIZE-1:0]   pad;
        logic [UART_CTRL_SIZE-1:0]        ctrl;
    } uart_ctrl_view_s;

    typedef union packed {
        uart_data_view_s data_v;
        uart_ctrl_view_s ctrl_v;
    } uart_word_u;

endpackage

`default_nettype wire

// File: logic/uart_bus_if.sv
`default_nettype none

// Request and response of a single UART channel
interface uart_bus_if;
    import uart_pkg::*;

    // Request side
    logic            sel;
    logic            req;
    logic            w_en;
    type_uart_regs_e reg_addr;
    logic [XLEN-1:0] w_data;

    // Response side
    logic            ack;
    logic [XLEN-1:0] r_data;
    logic            irq;

    modport decoder (output sel, req, w_en, reg_addr, w_data);

    modport channel (input sel, req, w_en, reg_addr, w_data, output ack, r_data, irq);

    modport merger (input ack, r_data, irq);

endinterface

`default_nettype wire

// File: logic/uart_bus_decoder.sv
`default_nettype none

module uart_bus_decoder #(
    parameter int NUM_CHANNELS = 4,
    parameter int ADDR_W       = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        bus_req_i,
    input  wire                        bus_w_en_i,
    input  wire [ADDR_W-1:0]           bus_addr_i,
    input  wire [uart_pkg::XLEN-1:0]   bus_w_data_i,

    uart_bus_if.decoder                ch_o [NUM_CHANNELS]
);
    import uart_pkg::*;

    localparam int CH_W = $clog2(NUM_CHANNELS);

    logic [CH_W-1:0]         ch_num;
    type_uart_regs_e         reg_idx;
    logic [NUM_CHANNELS-1:0] sel_vec;

    assign ch_num  = bus_addr_i[CH_ADDR_LSB +: CH_W];
    assign reg_idx = type_uart_regs_e'(bus_addr_i[CH_ADDR_LSB-1:2]);

    // Only the addressed channel is selected and the rest is broadcast
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
        assign sel_vec[i]       = (ch_num == CH_W'(i));
        assign ch_o[i].sel      = sel_vec[i];
        assign ch_o[i].req      = bus_req_i;
        assign ch_o[i].w_en     = bus_w_en_i;
        assign ch_o[i].reg_addr = reg_idx;
        assign ch_o[i].w_data   = bus_w_data_i;
    end

    // The master holds its request stable until the ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_i && $past(bus_req_i) |->
            $stable(bus_addr_i) && $stable(bus_w_en_i) && $stable(bus_w_data_i))
        else $error("bus request changed while held");

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire                                      clk,
    input  wire                                      rst_n,

    input  wire  [uart_pkg::UART_DATA_SIZE-1:0]      tx_data_i,
    input  wire                                      two_stop_bits_i,
    input  wire  [uart_pkg::UART_BAUD_DIV_SIZE-1:0]  baud_div_i,

    input  wire                                      valid_i,
    output logic                                     ready_o,
    output logic                                     tx_pin_o
);
    import uart_pkg::*;

    localparam int CNT_W   = UART_BAUD_DIV_SIZE + $clog2(BIT_TICKS_PER_DIV);
    // Start bit, data and up to two stop bits
    localparam int FRAME_W = UART_DATA_SIZE + 3;
    localparam int LEFT_W  = $clog2(FRAME_W + 1);

    logic [CNT_W-1:0]   tick_cnt_q;
    logic [CNT_W-1:0]   bit_last;
    logic [FRAME_W-1:0] shift_q;
    logic [LEFT_W-1:0]  bits_left_q;
    logic               busy_q;

    assign bit_last = CNT_W'((baud_div_i + 1) * BIT_TICKS_PER_DIV - 1);
    assign ready_o  = ~busy_q;
    // Ones shift in behind the frame, so the idle line stays high
    assign tx_pin_o = shift_q[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt_q  <= '0;
            shift_q     <= '1;
            bits_left_q <= '0;
            busy_q      <= 1'b0;
        end else if (!busy_q) begin
            if (valid_i) begin
                shift_q     <= {2'b11, tx_data_i, 1'b0};
                bits_left_q <= two_stop_bits_i ? LEFT_W'(FRAME_W) : LEFT_W'(FRAME_W - 1);
                tick_cnt_q  <= '0;
                busy_q      <= 1'b1;
            end
        end else if (tick_cnt_q >= bit_last) begin
            // End of one bit time
            tick_cnt_q  <= '0;
            shift_q     <= {1'b1, shift_q[FRAME_W-1:1]};
            bits_left_q <= bits_left_q - 1'b1;
            if (bits_left_q == LEFT_W'(1)) begin
                busy_q <= 1'b0;
            end
        end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) ready_o |-> tx_pin_o)
        else $error("tx line low while transmitter is ready");

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire                                      clk,
    input  wire                                      rst_n,

    input  wire                                      rx_pin_i,
    input  wire                                      rx_en_i,
    input  wire  [uart_pkg::UART_BAUD_DIV_SIZE-1:0]  baud_div_i,

    output logic [uart_pkg::UART_DATA_SIZE-1:0]      rx_data_o,
    output logic                                     valid_o,
    output logic                                     frame_err_o
);
    import uart_pkg::*;

    localparam int CNT_W = UART_BAUD_DIV_SIZE + $clog2(BIT_TICKS_PER_DIV);
    localparam int IDX_W = $clog2(UART_DATA_SIZE);

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_e;

    rx_state_e                 state_q;
    logic [1:0]                sync_q;
    logic                      line;
    logic                      line_prev_q;
    logic [CNT_W-1:0]          tick_cnt_q;
    logic [CNT_W-1:0]          bit_last;
    logic [CNT_W-1:0]          half_last;
    logic [IDX_W-1:0]          bit_idx_q;
    logic                      sample_data;
    logic [UART_DATA_SIZE-1:0] shift_q;

    assign line        = sync_q[1];
    assign bit_last    = CNT_W'((baud_div_i + 1) * BIT_TICKS_PER_DIV - 1);
    assign half_last   = CNT_W'((baud_div_i + 1) * BIT_TICKS_PER_DIV / 2 - 1);
    assign sample_data = (state_q == R_DATA) && (tick_cnt_q >= bit_last);
    assign rx_data_o   = shift_q;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q      <= 2'b11;
            line_prev_q <= 1'b1;
        end else begin
            sync_q      <= {sync_q[0], rx_pin_i};
            line_prev_q <= line;
        end
    end

    // Data bits, LSB first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shift_q <= {line, shift_q[UART_DATA_SIZE-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= R_IDLE;
            tick_cnt_q  <= '0;
            bit_idx_q   <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            tick_cnt_q  <= tick_cnt_q + 1'b1;
            if (!rx_en_i) begin
                state_q <= R_IDLE;
            end else begin
                case (state_q)
                    R_IDLE: begin
                        if (line_prev_q && !line) begin
                            state_q    <= R_START;
                            tick_cnt_q <= '0;
                        end
                    end
                    R_START: begin
                        // Re-check at half a bit so a glitch is ignored
                        if (tick_cnt_q >= half_last) begin
                            tick_cnt_q <= '0;
                            bit_idx_q  <= '0;
                            state_q    <= line ? R_IDLE : R_DATA;
                        end
                    end
                    R_DATA: begin
                        if (sample_data) begin
                            tick_cnt_q <= '0;
                            bit_idx_q  <= bit_idx_q + 1'b1;
                            if (bit_idx_q == IDX_W'(UART_DATA_SIZE - 1)) begin
                                state_q <= R_STOP;
                            end
                        end
                    end
                    R_STOP: begin
                        if (tick_cnt_q >= bit_last) begin
                            valid_o     <= line;
                            frame_err_o <= ~line;
                            state_q     <= R_IDLE;
                        end
                    end
                    default: state_q <= R_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/uart_channel.sv
`default_nettype none

module uart_channel (
    input  wire          clk,
    input  wire          rst_n,

    uart_bus_if.channel  bus_if,

    input  wire          rxd_i,
    output wire          txd_o
);
    import uart_pkg::*;

    // Control register bits
    localparam int TXCTRL_NSTOP = 1;
    localparam int RXCTRL_EN    = 0;

    logic                          access;
    logic                          wr_en;
    logic                          rd_en;
    logic                          ack_q;
    logic [XLEN-1:0]               r_data_q;
    uart_word_u                    wr_word;
    uart_word_u                    rd_word;

    logic [UART_DATA_SIZE-1:0]     tx_byte_q;
    logic                          tx_valid_q;
    logic                          tx_ready;
    logic [UART_DATA_SIZE-1:0]     rx_byte_q;
    logic [UART_DATA_SIZE-1:0]     rx_byte;
    logic                          rx_valid;
    logic                          frame_err;

    logic [UART_BAUD_DIV_SIZE-1:0] baud_q;
    logic [UART_CTRL_SIZE-1:0]     txctrl_q;
    logic [UART_CTRL_SIZE-1:0]     rxctrl_q;
    logic [UART_DATA_SIZE-1:0]     status_q;
    logic [UART_DATA_SIZE-1:0]     status_d;
    logic [UART_DATA_SIZE-1:0]     int_mask_q;

    // --------------------------------------------------
    // Bus access
    // --------------------------------------------------
    // No access in the cycle right after an ack
    assign access  = bus_if.sel & bus_if.req & ~ack_q;
    assign wr_en   = access & bus_if.w_en;
    assign rd_en   = access & ~bus_if.w_en;
    assign wr_word = uart_word_u'(bus_if.w_data);

    always_comb begin
        rd_word = '0;
        case (bus_if.reg_addr)
            TXDATA:   rd_word.data_v.flag = ~tx_ready;
            RXDATA: begin
                rd_word.data_v.flag = ~status_q[ST_RX_FULL];
                rd_word.data_v.data = rx_byte_q;
            end
            BAUD:     rd_word.ctrl_v.ctrl = UART_CTRL_SIZE'(baud_q);
            STATUS:   rd_word.ctrl_v.ctrl = UART_CTRL_SIZE'(status_q);
            TXCTRL:   rd_word.ctrl_v.ctrl = txctrl_q;
            RXCTRL:   rd_word.ctrl_v.ctrl = rxctrl_q;
            INT_MASK: rd_word.ctrl_v.ctrl = UART_CTRL_SIZE'(int_mask_q);
            default:  rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        r_data_q <= rd_en ? rd_word : '0;
    end

    assign bus_if.ack    = ack_q;
    assign bus_if.r_data = r_data_q;
    assign bus_if.irq    = |(status_q & int_mask_q);

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_comb begin
        status_d              = status_q;
        status_d[ST_TX_READY] = tx_ready;
        if (rx_valid) begin
            status_d[ST_RX_FULL] = 1'b1;
        end else if (rd_en && bus_if.reg_addr == RXDATA) begin
            status_d[ST_RX_FULL] = 1'b0;
        end
        // Frame error is cleared by reading it
        if (frame_err) begin
            status_d[ST_FRAME_ERR] = 1'b1;
        end else if (rd_en && bus_if.reg_addr == STATUS) begin
            status_d[ST_FRAME_ERR] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_byte_q             <= '0;
            tx_valid_q            <= 1'b0;
            rx_byte_q             <= '0;
            baud_q                <= BAUD_RESET;
            txctrl_q              <= '0;
            rxctrl_q              <= '0;
            int_mask_q            <= '0;
            status_q              <= '0;
            status_q[ST_TX_READY] <= 1'b1;
        end else begin
            // A byte written while busy is dropped
            tx_valid_q <= wr_en && bus_if.reg_addr == TXDATA && tx_ready;
            status_q   <= status_d;
            if (rx_valid) begin
                rx_byte_q <= rx_byte;
            end
            if (wr_en) begin
                case (bus_if.reg_addr)
                    TXDATA:   if (tx_ready) tx_byte_q <= wr_word.data_v.data;
                    BAUD:     baud_q     <= wr_word.ctrl_v.ctrl[UART_BAUD_DIV_SIZE-1:0];
                    TXCTRL:   txctrl_q   <= wr_word.ctrl_v.ctrl;
                    RXCTRL:   rxctrl_q   <= wr_word.ctrl_v.ctrl;
                    INT_MASK: int_mask_q <= wr_word.ctrl_v.ctrl[UART_DATA_SIZE-1:0];
                    default:  ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Serial side
    // --------------------------------------------------
    uart_tx u_tx (
        .clk             (clk),
        .rst_n           (rst_n),
        .tx_data_i       (tx_byte_q),
        .two_stop_bits_i (txctrl_q[TXCTRL_NSTOP]),
        .baud_div_i      (baud_q),
        .valid_i         (tx_valid_q),
        .ready_o         (tx_ready),
        .tx_pin_o        (txd_o)
    );

    uart_rx u_rx (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_pin_i        (rxd_i),
        .rx_en_i         (rxctrl_q[RXCTRL_EN]),
        .baud_div_i      (baud_q),
        .rx_data_o       (rx_byte),
        .valid_o         (rx_valid),
        .frame_err_o     (frame_err)
    );

    // The transmitter is still idle when its start strobe arrives
    a_tx_strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_q |-> tx_ready)
        else $error("start strobe while transmitter busy");

endmodule

`default_nettype wire

// File: logic/uart_resp_merge.sv
`default_nettype none

module uart_resp_merge #(
    parameter int NUM_CHANNELS = 4
) (
    uart_bus_if.merger                 ch_i [NUM_CHANNELS],

    output logic                       bus_ack_o,
    output logic [uart_pkg::XLEN-1:0]  bus_r_data_o,
    output logic                       uart_irq_o
);

    logic [NUM_CHANNELS-1:0] ack_vec;
    logic [NUM_CHANNELS-1:0] irq_vec;
    logic [uart_pkg::XLEN-1:0] r_data_arr [NUM_CHANNELS];

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
        assign ack_vec[i]    = ch_i[i].ack;
        assign irq_vec[i]    = ch_i[i].irq;
        assign r_data_arr[i] = ch_i[i].r_data;
    end

    // At most one channel acks at a time
    always_comb begin
        bus_r_data_o = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (ack_vec[i]) begin
                bus_r_data_o = r_data_arr[i];
            end
        end
    end

    assign bus_ack_o  = |ack_vec;
    assign uart_irq_o = |irq_vec;

endmodule

`default_nettype wire

// File: logic/uart_subsys_top.sv
`default_nettype none

module uart_subsys_top #(
    parameter int NUM_CHANNELS = 4,
    // Must cover the channel field above bit 5 (9 bits for 8 channels)
    parameter int ADDR_W       = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        bus_req_i,
    input  wire                        bus_w_en_i,
    input  wire [ADDR_W-1:0]           bus_addr_i,
    input  wire [uart_pkg::XLEN-1:0]   bus_w_data_i,

    output wire                        bus_ack_o,
    output wire [uart_pkg::XLEN-1:0]   bus_r_data_o,
    output wire                        uart_irq_o,

    input  wire [NUM_CHANNELS-1:0]     uart_rxd_i,
    output wire [NUM_CHANNELS-1:0]     uart_txd_o
);

    uart_bus_if ch_if [NUM_CHANNELS] ();

    uart_bus_decoder #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .ADDR_W       (ADDR_W)
    ) u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req_i    (bus_req_i),
        .bus_w_en_i   (bus_w_en_i),
        .bus_addr_i   (bus_addr_i),
        .bus_w_data_i (bus_w_data_i),
        .ch_o         (ch_if)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
        uart_channel u_channel (
            .clk    (clk),
            .rst_n  (rst_n),
            .bus_if (ch_if[i]),
            .rxd_i  (uart_rxd_i[i]),
            .txd_o  (uart_txd_o[i])
        );
    end

    uart_resp_merge #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_merge (
        .ch_i         (ch_if),
        .bus_ack_o    (bus_ack_o),
        .bus_r_data_o (bus_r_data_o),
        .uart_irq_o   (uart_irq_o)
    );

endmodule

`default_nettype wire

// File: verif/uart_subsys_tb.sv
`default_nettype none

module uart_subsys_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int NUM_CH     = 4;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 200;
    localparam logic [31:0] SEED = 32'h61a8_5eff;

    logic              clk;
    logic              rst_n;
    logic              bus_req;
    logic              bus_w_en;
    logic [7:0]        bus_addr;
    logic [XLEN-1:0]   bus_w_data;
    wire               bus_ack;
    wire  [XLEN-1:0]   bus_r_data;
    wire               uart_irq;
    wire  [NUM_CH-1:0] rxd;
    wire  [NUM_CH-1:0] txd;

    // Per-channel override of the loopback for bit-banged frames
    logic [NUM_CH-1:0] bang_sel;
    logic [NUM_CH-1:0] bang_q;

    // Divisor last written per channel, for bit-banged timing
    logic [UART_BAUD_DIV_SIZE-1:0] baud_sh [NUM_CH];

    int   pass_cnt;
    int   fail_cnt;
    int   test_num;
    int   test_checks;
    int   test_errs;
    logic aborted;

    assign rxd = (bang_sel & bang_q) | (~bang_sel & txd);

    uart_subsys_top uart_subsys_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req_i    (bus_req),
        .bus_w_en_i   (bus_w_en),
        .bus_addr_i   (bus_addr),
        .bus_w_data_i (bus_w_data),
        .bus_ack_o    (bus_ack),
        .bus_r_data_o (bus_r_data),
        .uart_irq_o   (uart_irq),
        .uart_rxd_i   (rxd),
        .uart_txd_o   (txd)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check(input string sig, input logic [31:0] expected,
                         input logic [31:0] actual);
        test_checks++;
        if (expected !== actual) begin
            $display("FAIL t=%0t %s: expected %h, got %h", $time, sig, expected, actual);
            fail_cnt++;
            test_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic close_test();
        $display("test %0d: %0d checks, %0d failed", test_num, test_checks, test_errs);
        test_num++;
        test_checks = 0;
        test_errs   = 0;
    endtask

    // --------------------------------------------------
    // Bus access
    // --------------------------------------------------
    // Drive on the rising edge, look at the response on the falling edge
    task automatic bus_access(input logic [1:0] ch, input logic [3:0] reg_idx,
                              input logic we, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        bus_req    <= 1'b1;
        bus_w_en   <= we;
        bus_addr   <= {ch, reg_idx, 2'b00};
        bus_w_data <= wdata;
        @(negedge clk);
        while (!bus_ack && waited < ACK_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!bus_ack) begin
            $display("timeout: channel %0d never acknowledged the request", ch);
            aborted = 1'b1;
        end else begin
            rdata = bus_r_data;
            check("bus_ack_o latency", 32'd1, waited);
        end
        @(posedge clk);
        bus_req <= 1'b0;
        repeat ($urandom_range(3, 1)) @(posedge clk);
    endtask

    task automatic write_reg(input logic [1:0] ch, input logic [3:0] reg_idx,
                             input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(ch, reg_idx, 1'b1, wdata, unused);
        if (reg_idx == BAUD) begin
            baud_sh[ch] = wdata[UART_BAUD_DIV_SIZE-1:0];
        end
    endtask

    task automatic read_and_compare(input logic [1:0] ch, input logic [3:0] reg_idx,
                                    input logic [31:0] expected);
        logic [31:0] rdata;
        bus_access(ch, reg_idx, 1'b0, '0, rdata);
        if (!aborted) begin
            check($sformatf("bus_r_data_o ch%0d reg%0d", ch, reg_idx), expected, rdata);
        end
    endtask

    // Poll STATUS until the given bit is set
    task automatic wait_status_bit(input logic [1:0] ch, input int bit_pos);
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[bit_pos] && polls < POLL_LIMIT && !aborted) begin
            bus_access(ch, STATUS, 1'b0, '0, st);
            polls++;
        end
        if (!st[bit_pos] && !aborted) begin
            $display("timeout: status bit %0d of channel %0d never set", bit_pos, ch);
            aborted = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Serial side
    // --------------------------------------------------
    // Start bit, data LSB first, then a stop bit held low
    task automatic send_bad_frame(input logic [1:0] ch, input logic [7:0] value);
        int         bit_cycles;
        logic [9:0] frame;
        bit_cycles = (baud_sh[ch] + 1) * BIT_TICKS_PER_DIV;
        frame      = {1'b0, value, 1'b0};
        @(posedge clk);
        bang_q[ch]   <= 1'b1;
        bang_sel[ch] <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            bang_q[ch] <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        bang_q[ch] <= 1'b1;
        repeat (2 * bit_cycles) @(posedge clk);
        bang_sel[ch] <= 1'b0;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [8*8-1:0]   op;
        logic [8*128-1:0] skip;
        logic [31:0]      ch;
        logic [31:0]      reg_idx;
        logic [31:0]      data;
        logic [31:0]      exp_val;
        int               fd;
        int               code;
        logic             done;

        clk         = 1'b0;
        rst_n       = 1'b0;
        bus_req     = 1'b0;
        bus_w_en    = 1'b0;
        bus_addr    = '0;
        bus_w_data  = '0;
        bang_sel    = '0;
        bang_q      = '1;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_num    = 1;
        test_checks = 0;
        test_errs   = 0;
        aborted     = 1'b0;
        done        = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            baud_sh[i] = BAUD_RESET;
        end
        void'($urandom(SEED));

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        fd = $fopen("verif/uart_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/uart_stim.txt");
            aborted = 1'b1;
        end

        while (fd != 0 && !done && !aborted) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(skip, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h", ch, reg_idx, data, exp_val);
                if (code != 4) begin
                    $display("stimulus line is missing fields");
                    aborted = 1'b1;
                end else begin
                    case (op)
                        "wr":   write_reg(ch[1:0], reg_idx[3:0], data);
                        "wrb": begin
                            write_reg(ch[1:0], reg_idx[3:0], data);
                            read_and_compare(ch[1:0], reg_idx[3:0], exp_val);
                        end
                        "rd":   read_and_compare(ch[1:0], reg_idx[3:0], exp_val);
                        "wait": wait_status_bit(ch[1:0], data);
                        "bad":  send_bad_frame(ch[1:0], data[7:0]);
                        "irq": begin
                            @(negedge clk);
                            check("uart_irq_o", exp_val, {31'b0, uart_irq});
                        end
                        "end":  close_test();
                        default: begin
                            $display("unknown operation in the stimulus file");
                            aborted = 1'b1;
                        end
                    endcase
                end
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !aborted) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/uart_stim.txt
# op ch reg data expected, all hex, reg is the register index 0..6
# wait polls STATUS for bit <data>, bad sends byte <data> with a low stop bit, irq checks the line
rd   0 3 0      00000001
rd   0 2 0      00000008
rd   0 1 0      80000000
rd   1 3 0      00000001
rd   1 2 0      00000008
rd   1 1 0      80000000
rd   2 3 0      00000001
rd   2 2 0      00000008
rd   2 1 0      80000000
rd   3 3 0      00000001
rd   3 2 0      00000008
rd   3 1 0      80000000
irq  0 0 0      0
end  0 0 0      0
wrb  0 2 3      00000003
wrb  0 4 0      00000000
wrb  0 5 1      00000001
wrb  0 6 0      00000000
wrb  1 2 5      00000005
wrb  1 4 2      00000002
wrb  1 5 3      00000003
wrb  1 6 2      00000002
wrb  2 2 14     00000004
wrb  2 4 f00    00000f00
wrb  2 5 41     00000041
wrb  2 6 10     00000010
wrb  3 2 6      00000006
wrb  3 4 123402 00023402
wrb  3 5 5      00000005
wrb  3 6 1ff    000000ff
rd   0 2 0      00000003
rd   1 2 0      00000005
rd   2 2 0      00000004
rd   3 2 0      00000006
end  0 0 0      0
wr   0 0 a5     0
rd   0 0 0      80000000
wait 0 0 1      0
rd   0 1 0      000000a5
rd   0 1 0      800000a5
wr   1 0 3c     0
rd   1 0 0      80000000
wait 1 0 1      0
rd   1 1 0      0000003c
rd   1 1 0      8000003c
wr   2 0 e1     0
rd   2 0 0      80000000
wait 2 0 1      0
rd   2 1 0      000000e1
rd   2 1 0      800000e1
wr   3 0 0f     0
rd   3 0 0      80000000
wait 3 0 1      0
rd   3 1 0      0000000f
rd   3 1 0      8000000f
wrb  0 4 2      00000002
wrb  0 2 1      00000001
wr   0 0 96     0
rd   0 0 0      80000000
wait 0 0 1      0
rd   0 1 0      00000096
rd   0 1 0      80000096
end  0 0 0      0
wrb  1 6 0      00000000
wrb  2 6 0      00000000
wrb  3 6 0      00000000
wrb  0 6 2      00000002
irq  0 0 0      0
wr   0 0 c3     0
wait 0 0 1      0
irq  0 0 0      1
rd   0 1 0      000000c3
irq  0 0 0      0
wrb  0 6 0      00000000
wr   2 0 77     0
wait 2 0 1      0
irq  0 0 0      0
rd   2 1 0      00000077
end  0 0 0      0
wrb  3 6 10     00000010
bad  3 0 5a     0
irq  0 0 0      1
rd   3 3 0      00000011
rd   3 3 0      00000001
irq  0 0 0      0
bad  2 0 a5     0
irq  0 0 0      0
rd   2 3 0      00000011
rd   2 3 0      00000001
end  0 0 0      0

// File: compile.f
logic/uart_pkg.sv
logic/uart_bus_if.sv
logic/uart_bus_decoder.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_channel.sv
logic/uart_resp_merge.sv
logic/uart_subsys_top.sv
verif/uart_subsys_tb.sv
